// File: hdl/wiscPkg.sv
// **************************************************
// WISC decode constants
// Data and register widths, instruction field
// positions, opcodes and branch condition codes
// **************************************************
package wiscPkg;

   // Datapath and register file sizes
   localparam int dataWidth    = 16;
   localparam int regAddrWidth = 3;
   localparam int numRegs      = 1 << regAddrWidth;   // Eight architectural registers

   // Jump-and-link forms write the return address here
   localparam logic [regAddrWidth-1:0] linkReg = 3'd7;

   // Instruction field layout
   // The opcode sits in the top five bits, Rs and Rt follow below it
   localparam int opWidth     = 5;
   localparam int opMsb       = dataWidth - 1;
   localparam int rsMsb       = 10;                    // Rs occupies bits 10 to 8
   localparam int rtMsb       = 7;                     // Rt occupies bits 7 to 5
   localparam int condMsb     = 12;                    // Branch condition in bits 12 to 11
   localparam int condWidth   = 2;
   localparam int prefixWidth = 3;                     // Top opcode bits shared by all branches

   // Jump-and-link-register opcodes
   // Both forms link through register 7 in decode
   localparam logic [opWidth-1:0] opJalr = 5'b00110;
   localparam logic [opWidth-1:0] opJal  = 5'b00111;

   // Any opcode of the form 011xx is a conditional branch
   localparam logic [prefixWidth-1:0] branchPrefix = 3'b011;

   // Condition codes, all tested against the Rs value
   localparam logic [condWidth-1:0] condEqz = 2'b00;   // Rs equals zero
   localparam logic [condWidth-1:0] condNez = 2'b01;   // Rs is not zero
   localparam logic [condWidth-1:0] condLtz = 2'b10;   // Rs is negative
   localparam logic [condWidth-1:0] condGez = 2'b11;   // Rs is zero or positive

   // Instructions are two bytes wide, so the sequential PC steps by two
   localparam logic [dataWidth-1:0] pcStep = 16'd2;

   // Stages between decode and writeback
   // A linking instruction reaches writeback this many edges after decode
   localparam int jalPipeDepth = 3;

endpackage

// File: hdl/regFile.sv
// **************************************************
// Register file, eight words of 16 bits
// Two combinational read ports with write bypass
// **************************************************
`timescale 1ns/1ps
`default_nettype none

module regFile (
   input  wire logic                             clk,
   input  wire logic                             rstN,
   input  wire logic [wiscPkg::regAddrWidth-1:0] readAddr1,   // Rs index
   input  wire logic [wiscPkg::regAddrWidth-1:0] readAddr2,   // Rt index
   input  wire logic [wiscPkg::regAddrWidth-1:0] writeAddr,
   input  wire logic [wiscPkg::dataWidth-1:0]    writeData,
   input  wire logic                             writeEn,
   output      logic [wiscPkg::dataWidth-1:0]    readData1,
   output      logic [wiscPkg::dataWidth-1:0]    readData2
);
   import wiscPkg::*;

   // Storage array, one entry per architectural register
   logic [dataWidth-1:0] regs [numRegs];

   // Bypass hits, a read that targets the word being written this cycle
   logic bypass1;
   logic bypass2;

   // Registers clear on reset so that software sees zeros
   // Writes land on the rising edge
   always_ff @(posedge clk) begin
      if (!rstN) begin
         for (int i = 0; i < numRegs; i++) begin
            regs[i] <= '0;
         end
      end else if (writeEn) begin
         regs[writeAddr] <= writeData;                  // Single write port
      end
   end

   assign bypass1 = writeEn && (writeAddr == readAddr1);
   assign bypass2 = writeEn && (writeAddr == readAddr2);

   // Read ports are purely combinational
   // The bypass returns the new value in the same cycle as its write
   assign readData1 = bypass1 ? writeData : regs[readAddr1];
   assign readData2 = bypass2 ? writeData : regs[readAddr2];

   // An unknown write address or data word would corrupt the array
   // for every later read, so both must be clean whenever a write is enabled
   writeClean : assert property (
      @(posedge clk) disable iff (!rstN)
      writeEn |-> !$isunknown({writeAddr, writeData})
   ) else $error("regFile write with unknown address or data");

endmodule

`default_nettype wire

// File: hdl/branchUnit.sv
// **************************************************
// Branch unit
// Spots jump-and-link and conditional branch
// opcodes and tests the condition on Rs
// **************************************************
`timescale 1ns/1ps
`default_nettype none

module branchUnit (
   input  wire logic [wiscPkg::dataWidth-1:0] instr,
   input  wire logic [wiscPkg::dataWidth-1:0] rsData,   // Rs value straight from the read port
   output      logic                          jalrOp,
   output      logic                          branchOp,
   output      logic                          taken
);
   import wiscPkg::*;

   logic [opWidth-1:0]     opcode;
   logic [prefixWidth-1:0] prefix;
   logic [condWidth-1:0]   cond;
   logic                   zeroFlag;
   logic                   signFlag;

   // Opcode, branch prefix and condition fields
   assign opcode = instr[opMsb -: opWidth];
   assign prefix = instr[opMsb -: prefixWidth];
   assign cond   = instr[condMsb -: condWidth];

   // Both link forms are handled the same way in decode
   assign jalrOp = (opcode == opJalr) || (opcode == opJal);

   // The three prefix bits alone mark a conditional branch
   assign branchOp = (prefix == branchPrefix);

   // Flags derived from Rs
   assign zeroFlag = (rsData == '0);
   assign signFlag = rsData[dataWidth-1];             // Two's complement sign

   // Condition select
   // The outcome is computed for every instruction, the qualifiers live in the top level
   always_comb begin
      taken = 1'b0;
      case (cond)
         condEqz: taken = zeroFlag;
         condNez: taken = !zeroFlag;
         condLtz: taken = signFlag;
         condGez: taken = !signFlag;                  // Zero counts as non-negative
         default: taken = 1'b0;
      endcase
   end

   // The link opcodes live under prefix 001 and branches under 011
   // so one instruction can never decode as both
   always_comb begin
      if (!$isunknown(instr)) begin
         assert (!(jalrOp && branchOp))
            else $error("branchUnit decoded link and branch together");
      end
   end

endmodule

`default_nettype wire

// File: hdl/decodeStage.sv
// **************************************************
// Instruction decode stage
// Register reads, writeback and early link writes,
// and branch resolution into a PC-select strobe
// **************************************************
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
   input  wire logic                             clk,
   input  wire logic                             rstN,
   input  wire logic [wiscPkg::dataWidth-1:0]    instr,        // Instruction in decode
   input  wire logic [wiscPkg::dataWidth-1:0]    imm,          // Immediate for load-byte-immediate
   input  wire logic [wiscPkg::dataWidth-1:0]    writeback,    // Result from the writeback stage
   input  wire logic [wiscPkg::dataWidth-1:0]    pcNow,        // PC of the instruction in decode
   input  wire logic [wiscPkg::regAddrWidth-1:0] writeRegAddr, // Destination from writeback
   input  wire logic                             lbi,
   input  wire logic                             link,
   input  wire logic                             en,           // Writeback wants a register write
   input  wire logic                             bFlag,
   input  wire logic                             jFlag,
   input  wire logic                             halt,
   output      logic [wiscPkg::dataWidth-1:0]    reg1Data,
   output      logic [wiscPkg::dataWidth-1:0]    reg2Data,
   output      logic                             pcSel
);
   import wiscPkg::*;

   // Read indices taken straight from the instruction
   logic [regAddrWidth-1:0] rsAddr;
   logic [regAddrWidth-1:0] rtAddr;

   // Write port selection
   logic [regAddrWidth-1:0] wrAddr;
   logic [dataWidth-1:0]    wrData;
   logic [dataWidth-1:0]    pcLink;
   logic [dataWidth-1:0]    immSel;
   logic                    wrEn;
   logic                    linkData;

   // Branch unit results
   logic jalrOp;
   logic branchOp;
   logic taken;

   // Link history
   // Bit 0 follows the linking instruction into execute,
   // the top bit marks it as it sits in writeback
   logic [jalPipeDepth-1:0] jalHist;
   logic                    jalInWb;

   assign rsAddr = instr[rsMsb -: regAddrWidth];
   assign rtAddr = instr[rtMsb -: regAddrWidth];

   // Shift register that carries jalrOp down to writeback
   always_ff @(posedge clk) begin
      if (!rstN) begin
         jalHist <= '0;
      end else begin
         jalHist <= {jalHist[jalPipeDepth-2:0], jalrOp};
      end
   end

   assign jalInWb = jalHist[jalPipeDepth-1];

   // Return address, the instruction after the one in decode
   assign pcLink = pcNow + pcStep;

   // Link data wins over lbi, and lbi wins over plain writeback
   // The history bit for execute is included as well, so a write in the cycle
   // right after a link instruction still carries the return address
   assign linkData = link || jalrOp || jalHist[0];
   assign immSel   = lbi ? imm : writeback;
   assign wrData   = linkData ? pcLink : immSel;

   // A linking instruction takes the write port at once and aims it at register 7
   assign wrAddr = jalrOp ? linkReg : writeRegAddr;

   // The same instruction is dropped when it reaches writeback,
   // since register 7 was already written three cycles earlier
   assign wrEn = jalrOp || (en && !jalInWb);

   regFile rfInst (
      .clk       (clk),
      .rstN      (rstN),
      .readAddr1 (rsAddr),
      .readAddr2 (rtAddr),
      .writeAddr (wrAddr),
      .writeData (wrData),
      .writeEn   (wrEn),
      .readData1 (reg1Data),
      .readData2 (reg2Data)
   );

   // Rs goes to the condition test after the bypass,
   // so a branch sees a value written in the same cycle
   branchUnit brInst (
      .instr    (instr),
      .rsData   (reg1Data),
      .jalrOp   (jalrOp),
      .branchOp (branchOp),
      .taken    (taken)
   );

   // Redirect the PC on a qualifying branch that is taken or forced by jFlag
   // A halted machine never redirects
   assign pcSel = (branchOp || bFlag) && !halt && (taken || jFlag);

   // Halt must hold the fetch PC whatever the flags say
   noRedirectOnHalt : assert property (
      @(posedge clk) disable iff (!rstN)
      halt |-> !pcSel
   ) else $error("decodeStage pcSel high while halted");

endmodule

`default_nettype wire

// File: dv/clkGen.sv
// **************************************************
// Testbench clock and reset source
// 8 ns clock, rstN held low for 16 cycles
// **************************************************
`timescale 1ns/1ps

module clkGen (
   output logic clk,
   output logic rstN
);
   localparam int halfPeriod  = 4;   // Half of the 8 ns period
   localparam int resetCycles = 16;

   initial begin
      clk = 1'b0;
      forever #halfPeriod clk = ~clk;
   end

   // Release lands on a falling edge so that no rising edge sees it change
   initial begin
      rstN = 1'b0;
      repeat (resetCycles) @(posedge clk);
      @(negedge clk);
      rstN = 1'b1;
   end

endmodule

// File: dv/decodeTb.sv
// **************************************************
// Decode stage testbench
// Directed and random traffic, register reads and
// pcSel compared against a model of the stage
// **************************************************
`timescale 1ns/1ps

module decodeTb;
   import wiscPkg::*;

   localparam int clkPeriod  = 8;
   localparam int randCycles = 300;
   // Reset, then the six tests in order, each with one settling edge
   localparam int testCycles = 17 + 9 + 109 + 29 + 25 + 52 + randCycles + 1;
   localparam int margin     = 100;

   // Plain opcode, neither a link form nor a branch, condition bits read as 11
   localparam logic [4:0] opPlain = 5'b11011;

   logic                    clk;
   logic                    rstN;
   logic [dataWidth-1:0]    instr;
   logic [dataWidth-1:0]    imm;
   logic [dataWidth-1:0]    writeback;
   logic [dataWidth-1:0]    pcNow;
   logic [regAddrWidth-1:0] writeRegAddr;
   logic                    lbi;
   logic                    link;
   logic                    en;
   logic                    bFlag;
   logic                    jFlag;
   logic                    halt;
   logic [dataWidth-1:0]    reg1Data;
   logic [dataWidth-1:0]    reg2Data;
   logic                    pcSel;

   // Model state
   logic [dataWidth-1:0]    modelRegs [numRegs];
   logic [jalPipeDepth-1:0] modelHist;   // Bit 0 is the cycle after decode

   int seed = 32'hedd7_dc5c;
   int checks;
   int errors;
   int testErr;
   bit compareOn;

   clkGen clkInst (
      .clk  (clk),
      .rstN (rstN)
   );

   decodeStage uut (
      .clk          (clk),
      .rstN         (rstN),
      .instr        (instr),
      .imm          (imm),
      .writeback    (writeback),
      .pcNow        (pcNow),
      .writeRegAddr (writeRegAddr),
      .lbi          (lbi),
      .link         (link),
      .en           (en),
      .bFlag        (bFlag),
      .jFlag        (jFlag),
      .halt         (halt),
      .reg1Data     (reg1Data),
      .reg2Data     (reg2Data),
      .pcSel        (pcSel)
   );

   // Opcode in bits 15 to 11, Rs in 10 to 8, Rt in 7 to 5
   function automatic logic [dataWidth-1:0] makeInstr(input logic [4:0] op,
         input logic [2:0] rs, input logic [2:0] rt);
      return {op, rs, rt, 5'b10101};
   endfunction

   function automatic logic isLinkOp(input logic [dataWidth-1:0] ins);
      return (ins[15:11] == opJalr) || (ins[15:11] == opJal);
   endfunction

   // Random opcode kept clear of link forms and branches
   function automatic logic [4:0] plainOp();
      logic [4:0] op;
      op = 5'($random(seed));
      if (op[4:1] == opJalr[4:1] || op[4:2] == branchPrefix) begin
         op[4] = 1'b1;   // Moves it into the upper opcode half
      end
      return op;
   endfunction

   // Zero, positive or negative Rs value
   function automatic logic [dataWidth-1:0] rsValue(input int kind);
      case (kind)
         0:       return '0;
         1:       return {1'b0, 15'($random(seed))} | 16'd1;
         default: return {1'b1, 15'($random(seed))};
      endcase
   endfunction

   // Write port of the stage as {enable, address, data}
   function automatic logic [dataWidth+regAddrWidth:0] writePort();
      logic                    we;
      logic [regAddrWidth-1:0] wa;
      logic [dataWidth-1:0]    wd;
      wa = isLinkOp(instr) ? linkReg : writeRegAddr;
      if (link || isLinkOp(instr) || modelHist[0]) begin
         wd = pcNow + pcStep;   // Return address beats everything
      end else if (lbi) begin
         wd = imm;
      end else begin
         wd = writeback;
      end
      we = isLinkOp(instr) || (en && !modelHist[jalPipeDepth-1]);   // Link reaching writeback is dropped
      return {we, wa, wd};
   endfunction

   // Expected {reg1Data, reg2Data, pcSel} for the inputs now applied
   function automatic logic [2*dataWidth:0] expectOut();
      logic [dataWidth+regAddrWidth:0] wp;
      logic [regAddrWidth-1:0]         wa;
      logic [dataWidth-1:0]            rsVal;
      logic [dataWidth-1:0]            rtVal;
      logic                            isBranch;
      logic                            cond;
      wp    = writePort();
      wa    = wp[dataWidth +: regAddrWidth];
      rsVal = modelRegs[instr[10:8]];
      rtVal = modelRegs[instr[7:5]];
      // A write in this cycle shows through on a matching read
      if (wp[dataWidth+regAddrWidth] && wa == instr[10:8]) begin
         rsVal = wp[dataWidth-1:0];
      end
      if (wp[dataWidth+regAddrWidth] && wa == instr[7:5]) begin
         rtVal = wp[dataWidth-1:0];
      end
      isBranch = (instr[15:13] == branchPrefix);
      case (instr[12:11])
         condEqz: cond = (rsVal == '0);
         condNez: cond = (rsVal != '0);
         condLtz: cond = rsVal[dataWidth-1];
         default: cond = !rsVal[dataWidth-1];   // Zero counts as non-negative
      endcase
      return {rsVal, rtVal, (isBranch || bFlag) && !halt && (cond || jFlag)};
   endfunction

   task automatic checkEq(input string what, input logic [dataWidth-1:0] got,
         input logic [dataWidth-1:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   // Model follows the stage on every rising edge
   always @(posedge clk) begin : modelProc
      logic [dataWidth+regAddrWidth:0] wp;
      if (!rstN) begin
         for (int i = 0; i < numRegs; i++) begin
            modelRegs[i] = '0;
         end
         modelHist = '0;
      end else begin
         wp = writePort();
         if (wp[dataWidth+regAddrWidth]) begin
            modelRegs[wp[dataWidth +: regAddrWidth]] = wp[dataWidth-1:0];
         end
         modelHist = {modelHist[jalPipeDepth-2:0], isLinkOp(instr)};
      end
   end

   // Sample 1 ns before each rising edge
   always begin : compareProc
      logic [2*dataWidth:0] exp;
      @(negedge clk);
      #3;
      if (compareOn) begin
         exp = expectOut();
         checkEq("reg1Data", reg1Data, exp[2*dataWidth -: dataWidth]);
         checkEq("reg2Data", reg2Data, exp[dataWidth:1]);
         checkEq("pcSel", 16'(pcSel), 16'(exp[0]));
      end
   end

   // Quiet inputs, a plain instruction with no write, branch or halt
   task automatic quietInputs();
      instr        = makeInstr(opPlain, 3'd0, 3'd0);
      imm          = '0;
      writeback    = '0;
      writeRegAddr = '0;
      lbi          = 1'b0;
      link         = 1'b0;
      en           = 1'b0;
      bFlag        = 1'b0;
      jFlag        = 1'b0;
      halt         = 1'b0;
   endtask

   // Next falling edge with quiet inputs, the PC moves on by one instruction
   task automatic step();
      @(negedge clk);
      pcNow = pcNow + pcStep;
      quietInputs();
   endtask

   task automatic loadReg(input logic [2:0] r, input logic [dataWidth-1:0] v);
      step();
      en           = 1'b1;
      writeRegAddr = r;
      writeback    = v;
   endtask

   task automatic readAll();
      for (int r = 0; r < numRegs; r++) begin
         step();
         instr = makeInstr(opPlain, 3'(r), 3'(numRegs - 1 - r));
      end
   endtask

   // Lets the last cycle be compared, then reports the test
   task automatic endTest(input string name);
      @(posedge clk);
      $display("Test %s finished with %0d errors", name, errors - testErr);
      testErr = errors;
   endtask

   initial begin : stimulus
      pcNow = 16'h0100;
      quietInputs();   // Every input holds a defined value from time zero
      wait (rstN === 1'b1);
      compareOn = 1'b1;

      readAll();   // Every register must read zero
      endTest("reset");

      for (int n = 0; n < 100; n++) begin
         step();
         en           = 1'b1;
         writeRegAddr = 3'($random(seed));
         writeback    = 16'($random(seed));
         imm          = 16'($random(seed));
         lbi          = 1'($random(seed));
         link         = (($random(seed) & 7) == 0);
         // Every fourth cycle reads the register it writes
         instr = makeInstr(plainOp(), (n % 4 == 0) ? writeRegAddr : 3'($random(seed)),
                           3'($random(seed)));
      end
      readAll();
      endTest("writeback");

      for (int n = 0; n < 4; n++) begin
         step();
         instr        = makeInstr(n[0] ? opJal : opJalr, linkReg, 3'(n));
         en           = 1'b1;   // Loses the port to the link write
         writeRegAddr = 3'd3;
         writeback    = 16'($random(seed));
         step();
         instr        = makeInstr(opPlain, linkReg, 3'd2);
         en           = 1'b1;   // Carries the return address
         writeRegAddr = 3'd2;
         writeback    = 16'($random(seed));
         step();
         en           = 1'b1;
         writeRegAddr = 3'd4;
         writeback    = 16'($random(seed));
         step();
         instr        = makeInstr(opPlain, 3'd5, 3'd4);
         en           = 1'b1;   // Link instruction in writeback, so no write
         writeRegAddr = 3'd5;
         writeback    = 16'($random(seed));
         step();
         instr        = makeInstr(opPlain, 3'd5, 3'd4);
      end
      readAll();
      endTest("link");

      for (int c = 0; c < 4; c++) begin
         for (int k = 0; k < 3; k++) begin
            loadReg(3'd1, rsValue(k));
            step();
            instr = makeInstr({branchPrefix, 2'(c)}, 3'd1, 3'd2);
         end
      end
      endTest("branch");

      for (int k = 0; k < 3; k++) begin
         loadReg(3'd1, rsValue(k));
         for (int f = 0; f < 16; f++) begin
            step();
            instr = makeInstr(f[0] ? {branchPrefix, 2'(k)} : opPlain, 3'd1, 3'd3);
            bFlag = f[1];
            jFlag = f[2];
            halt  = f[3];
         end
      end
      endTest("flags");

      for (int n = 0; n < randCycles; n++) begin
         step();
         instr        = 16'($random(seed));
         imm          = 16'($random(seed));
         writeback    = 16'($random(seed));
         pcNow        = 16'($random(seed));
         writeRegAddr = 3'($random(seed));
         lbi          = 1'($random(seed));
         link         = (($random(seed) & 7) == 0);
         en           = 1'($random(seed));
         bFlag        = 1'($random(seed));
         jFlag        = 1'($random(seed));
         halt         = (($random(seed) & 3) == 0);
      end
      endTest("random");

      compareOn = 1'b0;
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

   // Ends a run that overruns the summed test lengths
   initial begin : watchdog
      #((testCycles + margin) * clkPeriod);
      $display("Timeout: the tests did not finish within %0d cycles", testCycles + margin);
      $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

// File: src.f
hdl/wiscPkg.sv
hdl/regFile.sv
hdl/branchUnit.sv
hdl/decodeStage.sv
dv/clkGen.sv
dv/decodeTb.sv

// File: run.sh
#!/bin/sh
# Builds the decode stage testbench with Verilator and runs it.
# The run fails if the log holds the fail message or lacks the pass message.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
   --top-module decodeTb \
   -f src.f \
   -o decodeSim

./obj_dir/decodeSim | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
   echo "Simulation reported failure"
   exit 1
fi

if ! grep -q "TEST RESULT: PASS" sim.log; then
   echo "Simulation ended without a result"
   exit 1
fi

exit 0
